/* design/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int ECODE_W = 6;
    localparam int ESUB_W  = 9;
    localparam int IRQ_W   = 9;    // 8 hw lines plus the ipi on top
    localparam int LIE_W   = 12;   // sw[1:0], hw[9:2], timer, ipi

    localparam logic [ECODE_W-1:0] ECODE_INT = 6'h0;
    localparam logic [ECODE_W-1:0] ECODE_SYS = 6'hb;
    localparam logic [ECODE_W-1:0] ECODE_BRK = 6'hc;
    localparam logic [ECODE_W-1:0] ECODE_INE = 6'hd;

    // tcfg control bits
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;

    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4,
        OP_EXCP    = 3'd5
    } csr_op_e;

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h0,
        CSR_PRMD   = 14'h1,
        CSR_ECFG   = 14'h4,
        CSR_ESTAT  = 14'h5,
        CSR_ERA    = 14'h6,
        CSR_EENTRY = 14'hc,
        CSR_SAVE0  = 14'h30,
        CSR_SAVE1  = 14'h31,
        CSR_SAVE2  = 14'h32,
        CSR_SAVE3  = 14'h33,
        CSR_TID    = 14'h40,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_addr_e;

    typedef struct packed {
        logic               valid;
        csr_op_e            op;
        csr_addr_e          addr;
        logic [31:0]        wdata;
        logic [31:0]        wmask;
        logic [31:0]        pc;
        logic [ECODE_W-1:0] ecode;
        logic [ESUB_W-1:0]  esubcode;
    } csr_req_t;

    typedef struct packed {
        logic [1:0]         crmd_plv;
        logic               crmd_ie;
        logic               crmd_da;
        logic               crmd_pg;
        logic [1:0]         crmd_datf;
        logic [1:0]         crmd_datm;
        logic [1:0]         prmd_pplv;
        logic               prmd_pie;
        logic [LIE_W-1:0]   lie;
        logic [1:0]         is_sw;
        logic [ECODE_W-1:0] ecode;
        logic [ESUB_W-1:0]  esubcode;
        logic [31:0]        era;
        logic [31:6]        eentry;
        logic [31:0]        save0;
        logic [31:0]        save1;
        logic [31:0]        save2;
        logic [31:0]        save3;
        logic [31:0]        tid;
        logic [31:0]        tcfg;
        logic [31:0]        tval;
        logic               ti_flag;
    } csr_state_t;

    typedef struct packed {
        csr_op_e            op;
        csr_addr_e          addr;
        logic [31:0]        wdata;   // already mask-merged
        logic [31:0]        pc;
        logic [ECODE_W-1:0] ecode;
        logic [ESUB_W-1:0]  esubcode;
        logic               int_taken;
        logic               ti_clear;
    } csr_stage_t;

    typedef struct packed {
        logic        flush;
        logic [31:0] redirect_pc;
        logic [31:0] rdata;
        logic        excp_flush;
        logic        ertn_flush;
    } csr_resp_t;

endpackage

`default_nettype wire

/* design/csr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module csr_decode import csr_pkg::*; (
    input  csr_req_t         req,
    input  csr_state_t       state,
    input  logic [IRQ_W-1:0] irq,
    output csr_stage_t       stage_d,
    output csr_resp_t        resp_d,
    output logic             take
);

    logic [LIE_W-1:0] pending;
    logic             int_take;
    logic             entry;
    logic             is_write;
    logic [31:0]      old_val;
    logic [31:0]      merged;

    // lines line up with the lie bits
    assign pending = {irq[IRQ_W-1], state.ti_flag, irq[IRQ_W-2:0], state.is_sw};

    // a reported exception wins over a pending interrupt
    assign int_take = req.valid && (req.op != OP_EXCP) && state.crmd_ie &&
                      (|(pending & state.lie));
    assign entry    = (req.op == OP_EXCP) || int_take;
    assign is_write = !entry && (req.op == OP_CSRWR || req.op == OP_CSRXCHG);
    assign take     = req.valid;

    always_comb
    begin
        old_val = '0;
        case (req.addr)
            CSR_CRMD:
                old_val = {23'b0, state.crmd_datm, state.crmd_datf, state.crmd_pg,
                           state.crmd_da, state.crmd_ie, state.crmd_plv};
            CSR_PRMD:
                old_val = {29'b0, state.prmd_pie, state.prmd_pplv};
            CSR_ECFG:
                old_val = {19'b0, state.lie[LIE_W-1:10], 1'b0, state.lie[9:0]};
            CSR_ESTAT:
                old_val = {1'b0, state.esubcode, state.ecode, 3'b0, irq[IRQ_W-1],
                           state.ti_flag, 1'b0, irq[IRQ_W-2:0], state.is_sw};
            CSR_ERA:    old_val = state.era;
            CSR_EENTRY: old_val = {state.eentry, 6'b0};
            CSR_SAVE0:  old_val = state.save0;
            CSR_SAVE1:  old_val = state.save1;
            CSR_SAVE2:  old_val = state.save2;
            CSR_SAVE3:  old_val = state.save3;
            CSR_TID:    old_val = state.tid;
            CSR_TCFG:   old_val = state.tcfg;
            CSR_TVAL:   old_val = state.tval;
            default:    old_val = '0;   // ticlr reads zero
        endcase
    end

    assign merged = (req.op == OP_CSRXCHG) ? ((old_val & ~req.wmask) | (req.wdata & req.wmask))
                                           : req.wdata;

    always_comb
    begin
        stage_d.op        = req.op;
        stage_d.addr      = req.addr;
        stage_d.wdata     = merged;
        stage_d.pc        = req.pc;
        stage_d.ecode     = int_take ? ECODE_INT : req.ecode;
        stage_d.esubcode  = int_take ? '0 : req.esubcode;
        stage_d.int_taken = int_take;
        stage_d.ti_clear  = is_write && (req.addr == CSR_TICLR) && merged[0];
    end

    always_comb
    begin
        resp_d.flush = entry || is_write || (req.op == OP_ERTN);
        if (entry)
            resp_d.redirect_pc = {state.eentry, 6'b0};
        else if (req.op == OP_ERTN)
            resp_d.redirect_pc = state.era;
        else
            resp_d.redirect_pc = req.pc + 32'd4;
        resp_d.rdata      = old_val;
        resp_d.excp_flush = 1'b0;   // driven at commit
        resp_d.ertn_flush = 1'b0;
    end

    always_comb
    begin
        if (req.valid)
        begin
            assert (req.op inside {OP_NONE, OP_CSRRD, OP_CSRWR, OP_CSRXCHG, OP_ERTN, OP_EXCP})
            else $error("csr_decode: unknown op %0d on a valid request", req.op);
        end
    end

endmodule

`default_nettype wire

/* design/csr_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module csr_stage import csr_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       stall,
    input  logic       flush,
    input  logic       take,
    input  csr_stage_t stage_d,
    input  csr_resp_t  resp_d,
    output csr_stage_t stage_q,
    output logic       stage_valid,
    output csr_resp_t  resp
);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            stage_valid <= 1'b0;
            resp        <= '0;
        end
        else if (!stall)
        begin
            if (flush)
            begin
                stage_valid <= 1'b0;   // item dropped before commit
                resp        <= '0;
            end
            else
            begin
                stage_valid <= take;
                resp        <= take ? resp_d : '0;
            end
        end
    end

    // staged payload
    always_ff @(posedge clk)
    begin
        if (!stall)
            stage_q <= stage_d;
    end

    // the pipeline keeps a stalled request in place
    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(take) && $stable(stage_d.op) && $stable(stage_d.pc))
        else $error("csr_stage: request changed under stall");

endmodule

`default_nettype wire

/* design/csr_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module csr_regfile import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  csr_stage_t         stage_q,
    input  logic               stage_valid,
    input  logic [TIMER_W-1:0] tval,
    input  logic               ti_flag,
    output csr_state_t         state,
    output logic [TIMER_W-1:0] tcfg,
    output logic               tcfg_written,
    output logic               ti_clear,
    output logic               excp_flush,
    output logic               ertn_flush,
    output logic [2:0]         crmd_plv_ie
);

    csr_state_t  r;
    logic        commit;
    logic        entry;
    logic [31:0] w;

    assign commit = stage_valid && !stall;
    assign entry  = stage_q.int_taken || (stage_q.op == OP_EXCP);
    assign w      = stage_q.wdata;

    // timer fields come live from the timer
    always_comb
    begin
        state         = r;
        state.tval    = 32'(tval);
        state.ti_flag = ti_flag;
    end

    assign tcfg        = r.tcfg[TIMER_W-1:0];
    assign crmd_plv_ie = {r.crmd_ie, r.crmd_plv};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            r            <= '0;
            r.crmd_da    <= 1'b1;   // direct addressing out of reset
            tcfg_written <= 1'b0;
            ti_clear     <= 1'b0;
            excp_flush   <= 1'b0;
            ertn_flush   <= 1'b0;
        end
        else
        begin
            tcfg_written <= 1'b0;
            ti_clear     <= 1'b0;
            excp_flush   <= 1'b0;
            ertn_flush   <= 1'b0;
            if (commit)
            begin
                if (entry)
                begin
                    r.prmd_pplv <= r.crmd_plv;
                    r.prmd_pie  <= r.crmd_ie;
                    r.crmd_plv  <= 2'b0;
                    r.crmd_ie   <= 1'b0;
                    r.era       <= stage_q.pc;
                    r.ecode     <= stage_q.ecode;
                    r.esubcode  <= stage_q.esubcode;
                    excp_flush  <= 1'b1;
                end
                else if (stage_q.op == OP_ERTN)
                begin
                    r.crmd_plv <= r.prmd_pplv;
                    r.crmd_ie  <= r.prmd_pie;
                    ertn_flush <= 1'b1;
                end
                else if (stage_q.op == OP_CSRWR || stage_q.op == OP_CSRXCHG)
                begin
                    ti_clear <= stage_q.ti_clear;
                    case (stage_q.addr)
                        CSR_CRMD:
                        begin
                            r.crmd_plv  <= w[1:0];
                            r.crmd_ie   <= w[2];
                            if (w[3] ^ w[4])   // da and pg must differ
                            begin
                                r.crmd_da <= w[3];
                                r.crmd_pg <= w[4];
                            end
                            r.crmd_datf <= w[6:5];
                            r.crmd_datm <= w[8:7];
                        end
                        CSR_PRMD:
                        begin
                            r.prmd_pplv <= w[1:0];
                            r.prmd_pie  <= w[2];
                        end
                        CSR_ECFG:   r.lie    <= {w[12:11], w[9:0]};   // bit 10 reserved
                        CSR_ESTAT:  r.is_sw  <= w[1:0];   // only sw bits writable
                        CSR_ERA:    r.era    <= w;
                        CSR_EENTRY: r.eentry <= w[31:6];
                        CSR_SAVE0:  r.save0  <= w;
                        CSR_SAVE1:  r.save1  <= w;
                        CSR_SAVE2:  r.save2  <= w;
                        CSR_SAVE3:  r.save3  <= w;
                        CSR_TID:    r.tid    <= w;
                        CSR_TCFG:
                        begin
                            r.tcfg       <= 32'(w[TIMER_W-1:0]);
                            tcfg_written <= 1'b1;
                        end
                        default: ;   // tval, ticlr hold no state here
                    endcase
                end
            end
        end
    end

    // a ticlr commit brings the timer flag down
    a_ti_clear: assert property (@(posedge clk) disable iff (!rstn) ti_clear |=> !ti_flag)
        else $error("csr_regfile: timer flag still set after a ticlr write");

endmodule

`default_nettype wire

/* design/csr_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module csr_timer import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [TIMER_W-1:0] tcfg,
    input  logic               tcfg_written,
    input  logic               ti_clear,
    output logic [TIMER_W-1:0] tval,
    output logic               ti_flag
);

    logic               en;
    logic               periodic;
    logic [TIMER_W-1:0] init_val;
    logic               at_zero;

    assign en       = tcfg[TCFG_EN];
    assign periodic = tcfg[TCFG_PERIODIC];
    assign init_val = {tcfg[TIMER_W-1:2], 2'b00};
    assign at_zero  = (tval == '0);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval    <= '0;
            ti_flag <= 1'b0;
        end
        else
        begin
            // clear has priority over a new expiry
            if (ti_clear)
                ti_flag <= 1'b0;
            else if (en && at_zero && !tcfg_written)
                ti_flag <= 1'b1;

            if (!en)
                tval <= '0;
            else if (tcfg_written || (periodic && at_zero))
                tval <= init_val;   // reload
            else if (tval != '1)
                tval <= tval - 1'b1;   // one-shot parks at all ones
        end
    end

endmodule

`default_nettype wire

/* design/csr_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module csr_unit import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic             flush,
    input  csr_req_t         req,
    input  logic [IRQ_W-1:0] irq,
    output csr_resp_t        resp,
    output logic [2:0]       crmd_plv_ie
);

    csr_stage_t         stage_d;
    csr_stage_t         stage_q;
    csr_resp_t          resp_d;
    csr_resp_t          stage_resp;
    csr_state_t         state;
    logic               take;
    logic               stage_valid;
    logic [TIMER_W-1:0] tcfg;
    logic [TIMER_W-1:0] tval;
    logic               tcfg_written;
    logic               ti_clear;
    logic               ti_flag;
    logic               excp_flush;
    logic               ertn_flush;

    // flush pulses come from the commit side
    assign resp = '{flush:       stage_resp.flush,
                    redirect_pc: stage_resp.redirect_pc,
                    rdata:       stage_resp.rdata,
                    excp_flush:  excp_flush,
                    ertn_flush:  ertn_flush};

    csr_decode i_csr_decode (
        .req     (req),
        .state   (state),
        .irq     (irq),
        .stage_d (stage_d),
        .resp_d  (resp_d),
        .take    (take)
    );

    csr_stage i_csr_stage (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .take        (take),
        .stage_d     (stage_d),
        .resp_d      (resp_d),
        .stage_q     (stage_q),
        .stage_valid (stage_valid),
        .resp        (stage_resp)
    );

    csr_regfile #(.TIMER_W(TIMER_W)) i_csr_regfile (
        .clk          (clk),
        .rstn         (rstn),
        .stall        (stall),
        .stage_q      (stage_q),
        .stage_valid  (stage_valid),
        .tval         (tval),
        .ti_flag      (ti_flag),
        .state        (state),
        .tcfg         (tcfg),
        .tcfg_written (tcfg_written),
        .ti_clear     (ti_clear),
        .excp_flush   (excp_flush),
        .ertn_flush   (ertn_flush),
        .crmd_plv_ie  (crmd_plv_ie)
    );

    csr_timer #(.TIMER_W(TIMER_W)) i_csr_timer (
        .clk          (clk),
        .rstn         (rstn),
        .tcfg         (tcfg),
        .tcfg_written (tcfg_written),
        .ti_clear     (ti_clear),
        .tval         (tval),
        .ti_flag      (ti_flag)
    );

endmodule

`default_nettype wire

/* verif/tb_csr_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_csr_unit import csr_pkg::*; ();

    localparam int  HALF_NS     = 50;
    localparam int  POLL_LIMIT  = 20;
    localparam time WATCHDOG_NS = 1000000;

    logic             clk = 1'b0;
    logic             rstn;
    logic             stall;
    logic             flush;
    csr_req_t         req;
    logic [IRQ_W-1:0] irq;
    csr_resp_t        resp;
    logic [2:0]       crmd_plv_ie;

    int seed     = 91480;
    int errors   = 0;
    int timeouts = 0;

    // expectations change only on the falling edge
    logic        chk_resp  = 1'b0;
    logic        exp_flush = 1'b0;
    logic [31:0] exp_pc    = '0;
    logic [31:0] exp_rdata = '0;
    logic [31:0] rd_mask   = '1;
    logic        exp_excp  = 1'b0;
    logic        exp_ertn  = 1'b0;
    logic [2:0]  exp_mode  = 3'b000;
    logic [31:0] last_rdata;
    logic [31:0] pc_cnt    = 32'h1c00_0000;

    // reference copies of the CSRs
    logic [31:0]        m_crmd = 32'h8;   // da out of reset
    logic [31:0]        m_prmd = '0;
    logic [31:0]        m_ecfg = '0;
    logic [31:0]        m_era = '0;
    logic [31:0]        m_eentry = '0;
    logic [31:0]        m_tcfg = '0;
    logic [31:0]        m_save [4] = '{default: '0};
    logic [ECODE_W-1:0] m_ecode = '0;
    logic [ESUB_W-1:0]  m_esub = '0;
    logic               m_ti = 1'b0;

    csr_addr_e rw_addr [6] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_EENTRY};
    logic      seen;
    int        polls;

    csr_unit #(.TIMER_W(32)) i_csr_unit (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .req         (req),
        .irq         (irq),
        .resp        (resp),
        .crmd_plv_ie (crmd_plv_ie)
    );

    always #(HALF_NS) clk = ~clk;

    function automatic void report_mismatch(input string name, input logic [31:0] got,
                                            input logic [31:0] want);
        errors++;
        $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
    endfunction

    function automatic logic [31:0] expected_csr(input csr_addr_e addr);
        case (addr)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, irq[8], m_ti, 1'b0, irq[7:0], 2'b0};
            CSR_ERA:    return m_era;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            CSR_TCFG:   return m_tcfg;
            default:    return 32'h0;
        endcase
    endfunction

    function automatic void apply_write(input csr_addr_e addr, input logic [31:0] w);
        case (addr)
            CSR_CRMD:   m_crmd = w & 32'h1ff;
            CSR_PRMD:   m_prmd = w & 32'h7;
            CSR_ECFG:   m_ecfg = w & 32'h1bff;   // bit 10 reserved
            CSR_ERA:    m_era = w;
            CSR_EENTRY: m_eentry = w & 32'hffff_ffc0;
            CSR_SAVE0:  m_save[0] = w;
            CSR_SAVE1:  m_save[1] = w;
            CSR_SAVE2:  m_save[2] = w;
            CSR_SAVE3:  m_save[3] = w;
            CSR_TCFG:   m_tcfg = w;
            CSR_TICLR:
                if (w[0])
                    m_ti = 1'b0;
            default: ;
        endcase
    endfunction

    function automatic csr_req_t make_req(input csr_op_e op, input csr_addr_e addr,
                                          input logic [31:0] wdata, input logic [31:0] wmask,
                                          input logic [31:0] pc);
        return '{valid: 1'b1, op: op, addr: addr, wdata: wdata, wmask: wmask, pc: pc,
                 ecode: ECODE_SYS, esubcode: '0};
    endfunction

    // one request, one idle cycle, then the commit edge
    task automatic issue(input csr_op_e op, input csr_addr_e addr, input logic [31:0] wdata,
                         input logic [31:0] wmask, input logic as_int);
        logic        entry;
        logic [31:0] pc;
        logic [31:0] old;
        logic [31:0] merged;
        pc     = pc_cnt;
        pc_cnt = pc_cnt + 32'd4;
        entry  = (op == OP_EXCP) || as_int;
        old    = expected_csr(addr);
        merged = wdata;
        if (op == OP_CSRXCHG)
        begin
            for (int b = 0; b < 32; b++)
                merged[b] = wmask[b] ? wdata[b] : old[b];
        end
        @(negedge clk);
        req = make_req(op, addr, wdata, wmask, pc);
        @(posedge clk);
        @(negedge clk);
        req        = '0;
        last_rdata = resp.rdata;
        exp_flush  = entry || (op inside {OP_CSRWR, OP_CSRXCHG, OP_ERTN});
        exp_pc     = entry ? m_eentry : ((op == OP_ERTN) ? m_era : pc + 32'd4);
        exp_rdata  = old;
        chk_resp   = 1'b1;
        @(posedge clk);
        @(negedge clk);
        chk_resp = 1'b0;
        if (entry)
        begin
            m_prmd      = {29'b0, m_crmd[2:0]};
            m_crmd[2:0] = 3'b000;
            m_era       = pc;
            m_ecode     = as_int ? ECODE_INT : ECODE_SYS;
            m_esub      = '0;
        end
        else if (op == OP_ERTN)
            m_crmd[2:0] = m_prmd[2:0];
        else if (op == OP_CSRWR || op == OP_CSRXCHG)
            apply_write(addr, merged);
        exp_excp = entry;
        exp_ertn = (op == OP_ERTN) && !entry;
        exp_mode = m_crmd[2:0];
        @(posedge clk);
        @(negedge clk);
        exp_excp = 1'b0;
        exp_ertn = 1'b0;
    endtask

    a_flush: assert property (@(posedge clk) disable iff (!rstn)
        chk_resp |-> resp.flush == exp_flush)
        else report_mismatch("resp.flush", 32'($sampled(resp.flush)), 32'(exp_flush));
    a_pc: assert property (@(posedge clk) disable iff (!rstn)
        chk_resp |-> resp.redirect_pc == exp_pc)
        else report_mismatch("resp.redirect_pc", $sampled(resp.redirect_pc), exp_pc);
    a_rdata: assert property (@(posedge clk) disable iff (!rstn)
        chk_resp |-> (resp.rdata & rd_mask) == (exp_rdata & rd_mask))
        else report_mismatch("resp.rdata", $sampled(resp.rdata) & rd_mask, exp_rdata & rd_mask);
    a_excp: assert property (@(posedge clk) disable iff (!rstn) resp.excp_flush == exp_excp)
        else report_mismatch("resp.excp_flush", 32'($sampled(resp.excp_flush)), 32'(exp_excp));
    a_ertn: assert property (@(posedge clk) disable iff (!rstn) resp.ertn_flush == exp_ertn)
        else report_mismatch("resp.ertn_flush", 32'($sampled(resp.ertn_flush)), 32'(exp_ertn));
    a_mode: assert property (@(posedge clk) disable iff (!rstn) crmd_plv_ie == exp_mode)
        else report_mismatch("crmd_plv_ie", 32'($sampled(crmd_plv_ie)), 32'(exp_mode));

    initial
    begin
        #(WATCHDOG_NS);
        $display("simulation ran past its time limit");
        $display("test failed");
        $finish;
    end

    initial
    begin
        rstn  = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        req   = '0;
        irq   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        foreach (rw_addr[i])
            issue(OP_CSRWR, rw_addr[i], $random(seed), '0, 1'b0);
        foreach (rw_addr[i])
            issue(OP_CSRRD, rw_addr[i], '0, '0, 1'b0);

        issue(OP_CSRXCHG, CSR_SAVE1, $random(seed), $random(seed), 1'b0);
        issue(OP_CSRRD, CSR_SAVE1, '0, '0, 1'b0);

        // plv 3, ie 1, then a syscall and its return
        issue(OP_CSRWR, CSR_CRMD, 32'hf, '0, 1'b0);
        issue(OP_EXCP, CSR_CRMD, '0, '0, 1'b0);
        issue(OP_CSRRD, CSR_PRMD, '0, '0, 1'b0);
        issue(OP_CSRRD, CSR_ERA, '0, '0, 1'b0);
        issue(OP_ERTN, CSR_CRMD, '0, '0, 1'b0);

        issue(OP_CSRWR, CSR_ECFG, 32'h4, '0, 1'b0);   // irq line 0 sits at lie bit 2
        irq = 9'h001;
        issue(OP_CSRRD, CSR_SAVE0, '0, '0, 1'b1);
        irq = '0;
        issue(OP_CSRRD, CSR_ESTAT, '0, '0, 1'b0);
        issue(OP_CSRRD, CSR_ERA, '0, '0, 1'b0);

        // one-shot timer with initial value 16
        issue(OP_CSRWR, CSR_TCFG, 32'h11, '0, 1'b0);
        rd_mask = ~32'h800;
        seen    = 1'b0;
        polls   = 0;
        while (!seen && polls < POLL_LIMIT)
        begin
            issue(OP_CSRRD, CSR_ESTAT, '0, '0, 1'b0);
            seen  = last_rdata[11];
            polls = polls + 1;
        end
        if (!seen)
        begin
            timeouts++;
            $display("timer interrupt flag did not appear in estat");
        end
        m_ti    = 1'b1;
        rd_mask = '1;
        issue(OP_CSRRD, CSR_ESTAT, '0, '0, 1'b0);
        issue(OP_CSRWR, CSR_TICLR, 32'h1, '0, 1'b0);
        issue(OP_CSRRD, CSR_ESTAT, '0, '0, 1'b0);

        // crmd write held in the stage by stall
        exp_flush = 1'b1;
        exp_pc    = pc_cnt + 32'd4;
        exp_rdata = expected_csr(CSR_CRMD);
        @(negedge clk);
        req = make_req(OP_CSRWR, CSR_CRMD, 32'h9, '0, pc_cnt);
        @(posedge clk);
        @(negedge clk);
        req      = '0;
        stall    = 1'b1;
        chk_resp = 1'b1;
        repeat (3) @(negedge clk);
        stall    = 1'b0;
        chk_resp = 1'b0;
        @(negedge clk);
        apply_write(CSR_CRMD, 32'h9);
        exp_mode = m_crmd[2:0];
        pc_cnt   = pc_cnt + 32'd4;

        // flushed write must never land
        @(negedge clk);
        req   = make_req(OP_CSRWR, CSR_SAVE2, $random(seed), '0, pc_cnt);
        flush = 1'b1;
        @(posedge clk);
        @(negedge clk);
        req       = '0;
        flush     = 1'b0;
        exp_flush = 1'b0;
        exp_pc    = '0;
        exp_rdata = '0;
        chk_resp  = 1'b1;
        @(negedge clk);
        chk_resp = 1'b0;
        pc_cnt   = pc_cnt + 32'd4;
        issue(OP_CSRRD, CSR_SAVE2, '0, '0, 1'b0);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/csr_pkg.sv
design/csr_decode.sv
design/csr_stage.sv
design/csr_regfile.sv
design/csr_timer.sv
design/csr_unit.sv
verif/tb_csr_unit.sv

/* run.sh */
#!/bin/sh
# build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_csr_unit -o sim_csr_unit

./obj_dir/sim_csr_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without a failure report"
